/* tb.f */
hw/icache_pkg.sv
hw/fetch_stage.sv
hw/cache_arrays.sv
hw/refill_ctrl.sv
hw/icache_top.sv
verif/clk_gen.sv
verif/mem_bus_model.sv
verif/icache_tb.sv

/* verif/icache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    typedef struct packed {
        icache_pkg::addr_t      pc;
        icache_pkg::slot_mask_t mask;
        logic                   uncached;
        logic [7:0]             bp_cycles;
        icache_pkg::block_t     exp_insts;
        logic [3:0]             exp_reqs;
        icache_pkg::bus_len_t   exp_len;
    } row_t;

    localparam int                ROW_NS     = 2000;
    localparam int                WAIT_LIMIT = 200;
    localparam icache_pkg::word_t DATA_KEY   = 32'h5a5a0000;

    logic                    clk;
    logic                    rst_n;
    logic                    flush_i;
    logic                    req_valid_i;
    logic                    req_ready_o;
    logic                    resp_valid_o;
    logic                    resp_ready_i;
    logic                    addr_valid_o;
    logic                    bus_resp_ready;
    logic                    bus_data_valid;
    icache_pkg::fetch_req_t  req_i;
    icache_pkg::fetch_resp_t resp_o;
    icache_pkg::addr_t       addr_o;
    icache_pkg::bus_len_t    data_len_o;
    icache_pkg::word_t       bus_data;
    icache_pkg::addr_t       last_addr;
    icache_pkg::bus_len_t    last_len;
    int                      req_count;
    int                      cur_row;
    int                      watch_ns;
    row_t                    rows[$];

    clk_gen u_clk (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    mem_bus_model u_mem (
        .clk              (clk),
        .rst_n            (rst_n),
        .addr_valid_i     (addr_valid_o),
        .addr_i           (addr_o),
        .data_len_i       (data_len_o),
        .bus_resp_ready_o (bus_resp_ready),
        .bus_data_valid_o (bus_data_valid),
        .bus_data_o       (bus_data),
        .req_count_o      (req_count),
        .last_addr_o      (last_addr),
        .last_len_o       (last_len)
    );

    icache_top dut (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush_i          (flush_i),
        .req_valid_i      (req_valid_i),
        .req_i            (req_i),
        .req_ready_o      (req_ready_o),
        .resp_valid_o     (resp_valid_o),
        .resp_o           (resp_o),
        .resp_ready_i     (resp_ready_i),
        .addr_valid_o     (addr_valid_o),
        .addr_o           (addr_o),
        .data_len_o       (data_len_o),
        .bus_resp_ready_i (bus_resp_ready),
        .bus_data_valid_i (bus_data_valid),
        .bus_data_i       (bus_data)
    );

    function automatic icache_pkg::block_t expected_block(input icache_pkg::addr_t pc);
        icache_pkg::addr_t base;
        base = {pc[31:3], 3'b000};
        return {(base + 32'd4) ^ DATA_KEY, base ^ DATA_KEY};
    endfunction

    function automatic icache_pkg::addr_t expected_bus_addr(input row_t r);
        icache_pkg::addr_t base;
        base = {r.pc[31:3], 3'b000};
        if (r.uncached) begin
            // mask 10 fetches only the second word
            return (r.mask == 2'b10) ? base + 32'd4 : base;
        end
        return {r.pc[31:5], 5'b00000};
    endfunction

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_block(input icache_pkg::block_t got, input icache_pkg::block_t exp,
                               input string what);
        if (got !== exp) begin
            $display("Fail @ %0d ns: row %0d %s got %h expected %h",
                     $time, cur_row, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input icache_pkg::addr_t got, input icache_pkg::addr_t exp,
                              input string what);
        if (got !== exp) begin
            $display("Fail @ %0d ns: row %0d %s got %h expected %h",
                     $time, cur_row, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_len(input icache_pkg::bus_len_t got, input icache_pkg::bus_len_t exp,
                             input string what);
        if (got !== exp) begin
            $display("Fail @ %0d ns: row %0d %s got %0d expected %0d",
                     $time, cur_row, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_mask(input icache_pkg::slot_mask_t got,
                              input icache_pkg::slot_mask_t exp,
                              input string what);
        if (got !== exp) begin
            $display("Fail @ %0d ns: row %0d %s got %b expected %b",
                     $time, cur_row, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("Fail @ %0d ns: row %0d %s got %0d expected %0d",
                     $time, cur_row, what, got, exp);
            abort_run();
        end
    endtask

    task automatic add_row(input icache_pkg::addr_t pc, input icache_pkg::slot_mask_t mask,
                           input logic unc, input int bp, input int reqs, input int len);
        row_t r;
        r.pc        = pc;
        r.mask      = mask;
        r.uncached  = unc;
        r.bp_cycles = bp[7:0];
        r.exp_insts = expected_block(pc);
        r.exp_reqs  = reqs[3:0];
        r.exp_len   = len[7:0];
        rows.push_back(r);
    endtask

    task automatic build_table();
        // cold miss, then a hit in another block of the line
        add_row(32'h0000_0108, 2'b11, 1'b0, 0, 1, 8);
        add_row(32'h0000_0118, 2'b11, 1'b0, 0, 0, 0);
        // uncached reads leave the arrays alone
        add_row(32'h0000_0400, 2'b11, 1'b1, 0, 1, 2);
        add_row(32'h0000_0408, 2'b10, 1'b1, 0, 1, 1);
        add_row(32'h0000_0400, 2'b11, 1'b0, 0, 1, 8);
        // A, B, C share set 2
        add_row(32'h0000_1040, 2'b11, 1'b0, 0, 1, 8);
        add_row(32'h0000_2040, 2'b11, 1'b0, 0, 1, 8);
        add_row(32'h0000_3040, 2'b11, 1'b0, 0, 1, 8);
        add_row(32'h0000_2048, 2'b11, 1'b0, 0, 0, 0);
        add_row(32'h0000_1050, 2'b11, 1'b0, 0, 1, 8);
        // back-pressure on a hit and on a miss
        add_row(32'h0000_1058, 2'b11, 1'b0, 5, 0, 0);
        add_row(32'h0000_0610, 2'b11, 1'b0, 3, 1, 8);
        add_row(32'h0000_0800, 2'b00, 1'b0, 0, 0, 0);
        add_row(32'h0000_0110, 2'b11, 1'b0, 0, 0, 0);
        add_row(32'h0000_3048, 2'b11, 1'b0, 0, 0, 0);
    endtask

    task automatic check_response(input row_t r, input icache_pkg::block_t keep);
        check_addr(resp_o.pc, {r.pc[31:3], 3'b000}, "response pc");
        check_mask(resp_o.mask, r.mask, "response mask");
        check_block(resp_o.insts & keep, r.exp_insts & keep, "response insts");
    endtask

    task automatic run_row(input row_t r);
        icache_pkg::fetch_req_t req;
        icache_pkg::block_t     keep;
        int                     start_reqs;
        int                     cycles;
        int                     seen;
        int                     k;
        req.pc       = r.pc;
        req.mask     = r.mask;
        req.uncached = r.uncached;
        keep         = {{32{r.mask[1]}}, {32{r.mask[0]}}};
        start_reqs   = req_count;
        @(posedge clk);
        req_valid_i  <= 1'b1;
        req_i        <= req;
        resp_ready_i <= (r.bp_cycles == 0);
        cycles = 0;
        @(negedge clk);
        while (!req_ready_o) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("request of row %0d was never accepted", cur_row);
                abort_run();
            end
            @(negedge clk);
        end
        @(posedge clk);
        req_valid_i <= 1'b0;
        if (r.mask == 2'b00) begin
            seen = 0;
            repeat (6) begin
                @(negedge clk);
                seen = seen + resp_valid_o + addr_valid_o;
            end
            check_count(seen, 0, "cycles with response or bus request");
        end else begin
            cycles = 1;
            @(negedge clk);
            while (!resp_valid_o) begin
                cycles++;
                if (cycles > WAIT_LIMIT) begin
                    $display("no response arrived for row %0d", cur_row);
                    abort_run();
                end
                @(negedge clk);
            end
            if (r.exp_reqs == 0) begin
                check_count(cycles, 1, "hit latency");
            end
            check_response(r, keep);
            for (k = 0; k < r.bp_cycles; k++) begin
                @(posedge clk);
                if (k == r.bp_cycles - 1) begin
                    resp_ready_i <= 1'b1;
                end
                @(negedge clk);
                check_count(resp_valid_o, 1, "resp_valid while held");
                check_response(r, keep);
            end
            @(posedge clk);
        end
        check_count(req_count - start_reqs, r.exp_reqs, "new bus requests");
        if (r.exp_reqs != 0) begin
            check_addr(last_addr, expected_bus_addr(r), "bus address");
            check_len(last_len, r.exp_len, "data_len");
        end
    endtask

    // watchdog
    initial begin
        wait (watch_ns > 0);
        #(watch_ns);
        $display("timeout: the table did not finish within %0d ns", watch_ns);
        abort_run();
    end

    initial begin
        int i;
        flush_i      = 1'b0;
        req_valid_i  = 1'b0;
        req_i        = '0;
        resp_ready_i = 1'b1;
        cur_row      = 0;
        build_table();
        // one extra row of time covers reset
        watch_ns = (rows.size() + 1) * ROW_NS;
        wait (rst_n === 1'b1);
        @(posedge clk);
        for (i = 0; i < rows.size(); i++) begin
            cur_row = i;
            run_row(rows[i]);
        end
        repeat (2) @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/mem_bus_model.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_bus_model (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          addr_valid_i,
    input  wire  icache_pkg::addr_t      addr_i,
    input  wire  icache_pkg::bus_len_t   data_len_i,
    output logic                         bus_resp_ready_o,
    output logic                         bus_data_valid_o,
    output icache_pkg::word_t            bus_data_o,
    output int                           req_count_o,
    output icache_pkg::addr_t            last_addr_o,
    output icache_pkg::bus_len_t         last_len_o
);

    localparam icache_pkg::word_t DATA_KEY = 32'h5a5a0000;

    typedef enum logic [1:0] {
        M_IDLE,
        M_ADDR,
        M_ACCEPT,
        M_DATA
    } model_state_t;

    model_state_t         state;
    integer               seed = 32'hf55d;
    int                   gap;
    icache_pkg::addr_t    next_addr;
    icache_pkg::bus_len_t words_left;

    always @(posedge clk) begin
        if (!rst_n) begin
            state            <= M_IDLE;
            gap              <= 0;
            bus_resp_ready_o <= 1'b0;
            bus_data_valid_o <= 1'b0;
            bus_data_o       <= '0;
            req_count_o      <= 0;
            last_addr_o      <= '0;
            last_len_o       <= '0;
            next_addr        <= '0;
            words_left       <= '0;
        end else begin
            bus_resp_ready_o <= 1'b0;
            bus_data_valid_o <= 1'b0;
            case (state)
                M_IDLE: begin
                    if (addr_valid_i) begin
                        gap   <= {$random(seed)} % 4;
                        state <= M_ADDR;
                    end
                end
                M_ADDR: begin
                    if (gap == 0) begin
                        bus_resp_ready_o <= 1'b1;
                        state            <= M_ACCEPT;
                    end else begin
                        gap <= gap - 1;
                    end
                end
                M_ACCEPT: begin
                    // address taken at this edge
                    req_count_o <= req_count_o + 1;
                    last_addr_o <= addr_i;
                    last_len_o  <= data_len_i;
                    next_addr   <= addr_i;
                    words_left  <= data_len_i;
                    gap         <= {$random(seed)} % 4;
                    state       <= M_DATA;
                end
                default: begin
                    if (words_left == 0) begin
                        state <= M_IDLE;
                    end else if (gap == 0) begin
                        bus_data_valid_o <= 1'b1;
                        bus_data_o       <= next_addr ^ DATA_KEY;
                        next_addr        <= next_addr + 32'd4;
                        words_left       <= words_left - 1'b1;
                        gap              <= {$random(seed)} % 4;
                    end else begin
                        gap <= gap - 1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* verif/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

/* hw/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           flush_i,
    input  wire                           req_valid_i,
    input  wire  icache_pkg::fetch_req_t  req_i,
    output logic                          req_ready_o,
    output logic                          resp_valid_o,
    output icache_pkg::fetch_resp_t       resp_o,
    input  wire                           resp_ready_i,
    output logic                          addr_valid_o,
    output icache_pkg::addr_t             addr_o,
    output icache_pkg::bus_len_t          data_len_o,
    input  wire                           bus_resp_ready_i,
    input  wire                           bus_data_valid_i,
    input  wire  icache_pkg::word_t       bus_data_i
);

    icache_pkg::fetch_req_t                        cur_req;
    icache_pkg::set_idx_t                          rd_set;
    icache_pkg::block_idx_t                        rd_block;
    icache_pkg::array_wr_t                         array_wr;
    icache_pkg::set_idx_t                          flip_set;
    icache_pkg::tag_t   [icache_pkg::WAY_NUM-1:0]  tag;
    icache_pkg::way_sel_t                          valid;
    icache_pkg::block_t [icache_pkg::WAY_NUM-1:0]  data;
    logic                                          victim;
    logic                                          way_flip;
    logic                                          stall;
    logic                                          hold;

    fetch_stage u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (flush_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .stall_i     (stall),
        .hold_i      (hold),
        .rd_set_o    (rd_set),
        .rd_block_o  (rd_block),
        .cur_req_o   (cur_req)
    );

    cache_arrays u_arrays (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_set_i   (rd_set),
        .rd_block_i (rd_block),
        .wr_i       (array_wr),
        .flip_i     (way_flip),
        .flip_set_i (flip_set),
        .tag_o      (tag),
        .valid_o    (valid),
        .data_o     (data),
        .victim_o   (victim)
    );

    refill_ctrl u_refill (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush_i          (flush_i),
        .cur_req_i        (cur_req),
        .tag_i            (tag),
        .valid_i          (valid),
        .data_i           (data),
        .victim_i         (victim),
        .wr_o             (array_wr),
        .flip_o           (way_flip),
        .flip_set_o       (flip_set),
        .stall_o          (stall),
        .hold_o           (hold),
        .resp_valid_o     (resp_valid_o),
        .resp_o           (resp_o),
        .resp_ready_i     (resp_ready_i),
        .addr_valid_o     (addr_valid_o),
        .addr_o           (addr_o),
        .data_len_o       (data_len_o),
        .bus_resp_ready_i (bus_resp_ready_i),
        .bus_data_valid_i (bus_data_valid_i),
        .bus_data_i       (bus_data_i)
    );

endmodule

`default_nettype wire

/* hw/refill_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module refill_ctrl (
    input  wire                                              clk,
    input  wire                                              rst_n,
    input  wire                                              flush_i,
    input  wire  icache_pkg::fetch_req_t                     cur_req_i,
    input  wire  icache_pkg::tag_t   [icache_pkg::WAY_NUM-1:0] tag_i,
    input  wire  icache_pkg::way_sel_t                       valid_i,
    input  wire  icache_pkg::block_t [icache_pkg::WAY_NUM-1:0] data_i,
    input  wire                                              victim_i,
    output icache_pkg::array_wr_t                            wr_o,
    output logic                                             flip_o,
    output icache_pkg::set_idx_t                             flip_set_o,
    output logic                                             stall_o,
    output logic                                             hold_o,
    output logic                                             resp_valid_o,
    output icache_pkg::fetch_resp_t                          resp_o,
    input  wire                                              resp_ready_i,
    output logic                                             addr_valid_o,
    output icache_pkg::addr_t                                addr_o,
    output icache_pkg::bus_len_t                             data_len_o,
    input  wire                                              bus_resp_ready_i,
    input  wire                                              bus_data_valid_i,
    input  wire  icache_pkg::word_t                          bus_data_i
);

    icache_pkg::refill_state_t                 state_q;
    icache_pkg::refill_state_t                 state_d;
    icache_pkg::fetch_req_t                    pend_q;
    icache_pkg::fetch_req_t                    req;
    icache_pkg::fetch_resp_t                   resp_q;
    icache_pkg::fetch_resp_t                   hit_resp;
    icache_pkg::way_sel_t                      way_hit;
    icache_pkg::block_t                        hit_block;
    icache_pkg::word_t                         lo_q;
    icache_pkg::bus_len_t                      unc_len;
    logic [$clog2(icache_pkg::LINE_WORDS)-1:0] cnt_q;
    logic                                      victim_q;
    logic                                      drop_q;
    logic                                      need_fill;
    logic                                      unc_slot;
    logic                                      unc_last;

    always_comb begin
        hit_block = '0;
        for (int w = 0; w < icache_pkg::WAY_NUM; w++) begin
            way_hit[w] = valid_i[w] & (tag_i[w] == cur_req_i.pc[31:icache_pkg::TAG_LOW]);
            if (way_hit[w]) begin
                hit_block = hit_block | data_i[w];
            end
        end
    end

    assign hit_resp.pc    = {cur_req_i.pc[31:icache_pkg::BLOCK_LOW], 3'b000};
    assign hit_resp.mask  = cur_req_i.mask;
    assign hit_resp.insts = hit_block;

    assign need_fill = (state_q == icache_pkg::S_NORMAL) & (|cur_req_i.mask)
                     & (cur_req_i.uncached | ~(|way_hit)) & ~flush_i;

    // bus request comes from the live request only in S_NORMAL
    assign req     = (state_q == icache_pkg::S_NORMAL) ? cur_req_i : pend_q;
    assign unc_len = icache_pkg::bus_len_t'(req.mask[0]) + icache_pkg::bus_len_t'(req.mask[1]);
    assign addr_o  = req.uncached ?
                     {req.pc[31:icache_pkg::BLOCK_LOW], ~req.mask[0], 2'b00} :
                     {req.pc[31:icache_pkg::INDEX_LOW], 5'b00000};
    assign data_len_o = req.uncached ? unc_len : icache_pkg::bus_len_t'(icache_pkg::LINE_WORDS);

    // mask 10 starts at slot 1
    assign unc_slot   = (pend_q.mask == 2'b10) | cnt_q[0];
    assign unc_last   = (icache_pkg::bus_len_t'(cnt_q) + 1'b1 == unc_len);
    assign flip_set_o = pend_q.pc[icache_pkg::INDEX_HIGH:icache_pkg::INDEX_LOW];
    assign hold_o     = resp_valid_o & ~resp_ready_i;

    always_comb begin
        state_d      = state_q;
        stall_o      = 1'b0;
        addr_valid_o = 1'b0;
        resp_valid_o = 1'b0;
        resp_o       = resp_q;
        flip_o       = 1'b0;
        wr_o.set     = pend_q.pc[icache_pkg::INDEX_HIGH:icache_pkg::INDEX_LOW];
        wr_o.block   = {pend_q.pc[icache_pkg::INDEX_HIGH:icache_pkg::INDEX_LOW], cnt_q[2:1]};
        wr_o.data    = {bus_data_i, lo_q};
        wr_o.way     = victim_q ? 2'b10 : 2'b01;
        wr_o.tag     = pend_q.pc[31:icache_pkg::TAG_LOW];
        wr_o.data_we = 1'b0;
        wr_o.tag_we  = 1'b0;
        case (state_q)
            icache_pkg::S_NORMAL: begin
                resp_o = hit_resp;
                if (need_fill) begin
                    stall_o      = 1'b1;
                    addr_valid_o = 1'b1;
                    if (cur_req_i.uncached) begin
                        state_d = bus_resp_ready_i ? icache_pkg::S_UNCACHE_DATA
                                                   : icache_pkg::S_UNCACHE;
                    end else begin
                        state_d = bus_resp_ready_i ? icache_pkg::S_MISS_DATA
                                                   : icache_pkg::S_MISS;
                    end
                end else if ((|cur_req_i.mask) && !flush_i) begin
                    resp_valid_o = 1'b1;
                    if (!resp_ready_i) begin
                        state_d = icache_pkg::S_HOLD;
                    end
                end
            end
            icache_pkg::S_MISS, icache_pkg::S_UNCACHE: begin
                stall_o      = 1'b1;
                addr_valid_o = 1'b1;
                if (bus_resp_ready_i) begin
                    state_d = (state_q == icache_pkg::S_MISS) ? icache_pkg::S_MISS_DATA
                                                              : icache_pkg::S_UNCACHE_DATA;
                end
            end
            icache_pkg::S_MISS_DATA: begin
                stall_o = 1'b1;
                // every odd word completes a block
                if (bus_data_valid_i && cnt_q[0]) begin
                    wr_o.data_we = 1'b1;
                    if (&cnt_q) begin
                        wr_o.tag_we = 1'b1;
                        flip_o      = 1'b1;
                        state_d     = (drop_q || flush_i) ? icache_pkg::S_NORMAL
                                                          : icache_pkg::S_HOLD;
                    end
                end
            end
            icache_pkg::S_UNCACHE_DATA: begin
                stall_o = 1'b1;
                if (bus_data_valid_i && unc_last) begin
                    state_d = (drop_q || flush_i) ? icache_pkg::S_NORMAL : icache_pkg::S_HOLD;
                end
            end
            icache_pkg::S_HOLD: begin
                resp_valid_o = ~flush_i;
                if (resp_ready_i || flush_i) begin
                    state_d = icache_pkg::S_NORMAL;
                end
            end
            default: begin
                state_d = icache_pkg::S_NORMAL;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= icache_pkg::S_NORMAL;
            cnt_q   <= '0;
            drop_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == icache_pkg::S_MISS_DATA || state_q == icache_pkg::S_UNCACHE_DATA) begin
                if (bus_data_valid_i) begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end else begin
                cnt_q <= '0;
            end
            // a flush mid-fill lets the line finish but drops the response
            if (state_d == icache_pkg::S_NORMAL) begin
                drop_q <= 1'b0;
            end else if (flush_i) begin
                drop_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == icache_pkg::S_NORMAL) begin
            pend_q   <= cur_req_i;
            victim_q <= victim_i;
            resp_q   <= hit_resp;
            if (need_fill) begin
                resp_q.insts <= '0;
            end
        end
        if (bus_data_valid_i) begin
            if (state_q == icache_pkg::S_UNCACHE_DATA) begin
                resp_q.insts[32*unc_slot +: 32] <= bus_data_i;
            end
            if (state_q == icache_pkg::S_MISS_DATA) begin
                lo_q <= bus_data_i;
                // grab the requested block on its way into the array
                if (cnt_q[0] && cnt_q[2:1] == pend_q.pc[4:3]) begin
                    resp_q.insts <= {bus_data_i, lo_q};
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/cache_arrays.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_arrays (
    input  wire                                              clk,
    input  wire                                              rst_n,
    input  wire  icache_pkg::set_idx_t                       rd_set_i,
    input  wire  icache_pkg::block_idx_t                     rd_block_i,
    input  wire  icache_pkg::array_wr_t                      wr_i,
    input  wire                                              flip_i,
    input  wire  icache_pkg::set_idx_t                       flip_set_i,
    output icache_pkg::tag_t   [icache_pkg::WAY_NUM-1:0]     tag_o,
    output icache_pkg::way_sel_t                             valid_o,
    output icache_pkg::block_t [icache_pkg::WAY_NUM-1:0]     data_o,
    output logic                                             victim_o
);

    logic [icache_pkg::SET_NUM-1:0] repl_q;
    icache_pkg::tag_t               wr_tag_q;
    icache_pkg::block_t             wr_data_q;

    // last write payload, shared by both ways for forwarding
    always_ff @(posedge clk) begin
        wr_tag_q  <= wr_i.tag;
        wr_data_q <= wr_i.data;
    end

    // one toggle bit per set picks the next victim way
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            repl_q   <= '0;
            victim_o <= 1'b0;
        end else begin
            if (flip_i) begin
                repl_q[flip_set_i] <= ~repl_q[flip_set_i];
            end
            victim_o <= repl_q[rd_set_i];
        end
    end

    for (genvar w = 0; w < icache_pkg::WAY_NUM; w++) begin : g_way
        icache_pkg::tag_t               tag_mem  [icache_pkg::SET_NUM];
        icache_pkg::block_t             data_mem [icache_pkg::BLOCK_DEPTH];
        logic [icache_pkg::SET_NUM-1:0] valid_q;
        icache_pkg::tag_t               tag_rd_q;
        icache_pkg::block_t             data_rd_q;
        logic                           valid_rd_q;
        logic                           tag_fwd_q;
        logic                           data_fwd_q;
        logic                           tag_wr;
        logic                           data_wr;

        assign tag_wr  = wr_i.tag_we & wr_i.way[w];
        assign data_wr = wr_i.data_we & wr_i.way[w];

        always_ff @(posedge clk) begin
            if (tag_wr) begin
                tag_mem[wr_i.set] <= wr_i.tag;
            end
            if (data_wr) begin
                data_mem[wr_i.block] <= wr_i.data;
            end
            tag_rd_q  <= tag_mem[rd_set_i];
            data_rd_q <= data_mem[rd_block_i];
        end

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                valid_q    <= '0;
                valid_rd_q <= 1'b0;
                tag_fwd_q  <= 1'b0;
                data_fwd_q <= 1'b0;
            end else begin
                if (tag_wr) begin
                    valid_q[wr_i.set] <= 1'b1;
                end
                valid_rd_q <= valid_q[rd_set_i];
                // memory returns old contents on a same-cycle write
                tag_fwd_q  <= tag_wr & (wr_i.set == rd_set_i);
                data_fwd_q <= data_wr & (wr_i.block == rd_block_i);
            end
        end

        assign tag_o[w]   = tag_fwd_q ? wr_tag_q : tag_rd_q;
        assign valid_o[w] = tag_fwd_q | valid_rd_q;
        assign data_o[w]  = data_fwd_q ? wr_data_q : data_rd_q;
    end

endmodule

`default_nettype wire

/* hw/fetch_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          flush_i,
    input  wire                          req_valid_i,
    input  wire  icache_pkg::fetch_req_t req_i,
    output logic                         req_ready_o,
    input  wire                          stall_i,
    input  wire                          hold_i,
    output icache_pkg::set_idx_t         rd_set_o,
    output icache_pkg::block_idx_t       rd_block_o,
    output icache_pkg::fetch_req_t       cur_req_o
);

    icache_pkg::fetch_req_t cur_req_q;
    icache_pkg::addr_t      rd_pc;
    logic                   busy;

    assign busy        = stall_i | hold_i;
    assign req_ready_o = ~busy;

    // arrays see the incoming pc so their outputs line up with cur_req
    // while busy they keep reading the held pc
    assign rd_pc      = busy ? cur_req_q.pc : req_i.pc;
    assign rd_set_o   = rd_pc[icache_pkg::INDEX_HIGH:icache_pkg::INDEX_LOW];
    assign rd_block_o = rd_pc[icache_pkg::INDEX_HIGH:icache_pkg::BLOCK_LOW];

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            cur_req_q <= '0;
        end else if (!busy) begin
            // empty mask when nothing is offered
            cur_req_q <= req_valid_i ? req_i : '0;
        end
    end

    assign cur_req_o = cur_req_q;

endmodule

`default_nettype wire

/* hw/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    // geometry
    localparam int WAY_NUM     = 2;
    localparam int SET_NUM     = 128;
    localparam int LINE_WORDS  = 8;
    localparam int INDEX_LOW   = 5;
    localparam int INDEX_HIGH  = 11;
    localparam int TAG_LOW     = 12;
    localparam int BLOCK_LOW   = 3;
    // four 64-bit blocks per line
    localparam int BLOCK_DEPTH = SET_NUM * 4;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [63:0] block_t;
    typedef logic [19:0] tag_t;
    typedef logic [6:0]  set_idx_t;
    typedef logic [8:0]  block_idx_t;
    typedef logic [1:0]  slot_mask_t;
    typedef logic [1:0]  way_sel_t;
    typedef logic [7:0]  bus_len_t;

    typedef struct packed {
        addr_t      pc;
        slot_mask_t mask;
        logic       uncached;
    } fetch_req_t;

    // slot 0 sits in the low word of insts
    typedef struct packed {
        addr_t      pc;
        slot_mask_t mask;
        block_t     insts;
    } fetch_resp_t;

    typedef struct packed {
        set_idx_t   set;
        block_idx_t block;
        block_t     data;
        way_sel_t   way;
        tag_t       tag;
        logic       data_we;
        logic       tag_we;
    } array_wr_t;

    typedef enum logic [2:0] {
        S_NORMAL,
        S_MISS,
        S_MISS_DATA,
        S_UNCACHE,
        S_UNCACHE_DATA,
        S_HOLD
    } refill_state_t;

endpackage

`default_nettype wire
